// ==== logic/lsu_pkg.sv ====
package lsu_pkg;

	localparam int DATA_W = 32;
	localparam int BUS_W  = 64;
	localparam int ADDR_W = 32;
	localparam int REG_W  = 5;
	localparam int ID_W   = 4;

	// device window that only takes byte-sized transfers
	localparam logic [ADDR_W-1:0] UART_BASE = 32'h1000_0000;
	localparam logic [ADDR_W-1:0] UART_LAST = 32'h1000_0fff;

	localparam logic [2:0] SIZE_BYTE = 3'd0;
	localparam logic [2:0] SIZE_WORD = 3'd2;
	localparam logic [1:0] RESP_OKAY = 2'd0;

	typedef enum logic [2:0] {
		LB  = 3'd0,
		LH  = 3'd1,
		LW  = 3'd2,
		LBU = 3'd3,
		LHU = 3'd4,
		SB  = 3'd5,
		SH  = 3'd6,
		SW  = 3'd7
	} mem_op_e;

	function automatic logic is_load(mem_op_e op);
		return op inside {LB, LH, LW, LBU, LHU};
	endfunction

	function automatic logic is_store(mem_op_e op);
		return op inside {SB, SH, SW};
	endfunction

	typedef struct packed {
		mem_op_e           op;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [REG_W-1:0]  rd;
	} lsu_req_t;

	// one bus beat, word aligned
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [3:0]        strb;
		logic [4:0]        shift;
	} beat_t;

	typedef struct packed {
		beat_t      first;
		beat_t      second;
		logic       need_second;
		logic [2:0] size;
	} access_plan_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [ID_W-1:0]   id;
		logic [2:0]        size;
	} axi_ar_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [ID_W-1:0]   id;
		logic [2:0]        size;
	} axi_aw_t;

	typedef struct packed {
		logic [BUS_W-1:0]   data;
		logic [BUS_W/8-1:0] strb;
		logic               last;
	} axi_w_t;

	typedef struct packed {
		logic [BUS_W-1:0] data;
		logic [1:0]       resp;
		logic [ID_W-1:0]  id;
		logic             last;
	} axi_r_t;

	typedef struct packed {
		logic [1:0]      resp;
		logic [ID_W-1:0] id;
	} axi_b_t;

endpackage

// ==== logic/lsu_access_planner.sv ====
`timescale 1ns/1ps

module lsu_access_planner (
	input  lsu_pkg::mem_op_e             op,
	input  logic [lsu_pkg::ADDR_W-1:0]   addr,
	output lsu_pkg::access_plan_t        plan
);
	import lsu_pkg::*;

	logic [1:0]        off;
	logic [3:0]        size_mask;
	logic [7:0]        wide_strb;
	logic [ADDR_W-1:0] base_addr;
	logic [4:0]        byte_shift;
	logic              in_uart;

	assign off = addr[1:0];
	assign base_addr = {addr[ADDR_W-1:2], 2'b00};
	assign byte_shift = {off, 3'b000};

	// bytes touched by the access, before alignment
	always_comb begin
		case (op)
			LB, LBU, SB: size_mask = 4'b0001;
			LH, LHU, SH: size_mask = 4'b0011;
			default:     size_mask = 4'b1111;
		endcase
	end

	// upper nibble holds the lanes that spill into the next word
	assign wide_strb = {4'b0000, size_mask} << off;

	assign in_uart = (addr >= UART_BASE) && (addr <= UART_LAST);

	always_comb begin
		plan.first.addr  = base_addr;
		plan.first.strb  = wide_strb[3:0];
		plan.first.shift = byte_shift;

		plan.second.addr = base_addr + ADDR_W'(4);
		plan.second.strb = wide_strb[7:4];
		// 32 - 8*off, wraps to 0 when the access is aligned
		plan.second.shift = 5'd0 - byte_shift;

		plan.need_second = |wide_strb[7:4];
		plan.size = in_uart ? SIZE_BYTE : SIZE_WORD;
	end

endmodule

// ==== logic/axi_read_ctrl.sv ====
`timescale 1ns/1ps

module axi_read_ctrl (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         start,
	input  lsu_pkg::access_plan_t        plan,
	output lsu_pkg::axi_ar_t             ar,
	output logic                         arvalid,
	input  logic                         arready,
	input  lsu_pkg::axi_r_t              r,
	input  logic                         rvalid,
	output logic                         rready,
	output logic [lsu_pkg::DATA_W-1:0]   first_word,
	output logic [lsu_pkg::DATA_W-1:0]   last_word,
	output logic                         done
);
	import lsu_pkg::*;

	typedef enum logic [1:0] {
		R_IDLE,
		R_ADDR_WAIT,
		R_RESP_WAIT,
		R_SECOND_ISSUE
	} rd_state_e;

	rd_state_e         state;
	logic              second;
	logic [ID_W-1:0]   id_cnt;
	logic [ID_W-1:0]   issued_id;
	logic [DATA_W-1:0] first_q;
	logic [DATA_W-1:0] last_q;
	logic              r_match;

	// second beat request goes out straight from the issue state
	assign arvalid = (state == R_ADDR_WAIT) || (state == R_SECOND_ISSUE);
	assign rready  = (state == R_RESP_WAIT);
	assign r_match = rvalid && (r.id == issued_id);

	always_comb begin
		ar.addr = second ? plan.second.addr : plan.first.addr;
		ar.id   = id_cnt;
		ar.size = plan.size;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= R_IDLE;
			second    <= 1'b0;
			id_cnt    <= '0;
			issued_id <= '0;
			done      <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				R_IDLE: begin
					if (start) begin
						second <= 1'b0;
						state  <= R_ADDR_WAIT;
					end
				end
				R_ADDR_WAIT, R_SECOND_ISSUE: begin
					if (arready) begin
						issued_id <= id_cnt;
						id_cnt    <= id_cnt + 1'b1;
						state     <= R_RESP_WAIT;
					end else begin
						state <= R_ADDR_WAIT;
					end
				end
				R_RESP_WAIT: begin
					// foreign ids stay on the bus untouched
					if (r_match) begin
						if (plan.need_second && !second) begin
							second <= 1'b1;
							state  <= R_SECOND_ISSUE;
						end else begin
							done  <= 1'b1;
							state <= R_IDLE;
						end
					end
				end
				default: state <= R_IDLE;
			endcase
		end
	end

	// slave answers the word in both halves, low half is enough
	always_ff @(posedge clock) begin
		if (r_match && rready) begin
			last_q <= r.data[DATA_W-1:0];
			if (plan.need_second && !second)
				first_q <= r.data[DATA_W-1:0];
		end
	end

	assign first_word = plan.need_second ? first_q : last_q;
	assign last_word  = last_q;

endmodule

// ==== logic/axi_write_ctrl.sv ====
`timescale 1ns/1ps

module axi_write_ctrl (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         start,
	input  lsu_pkg::access_plan_t        plan,
	input  logic [lsu_pkg::DATA_W-1:0]   store_data,
	output lsu_pkg::axi_aw_t             aw,
	output logic                         awvalid,
	input  logic                         awready,
	output lsu_pkg::axi_w_t              w,
	output logic                         wvalid,
	input  logic                         wready,
	input  lsu_pkg::axi_b_t              b,
	input  logic                         bvalid,
	output logic                         bready,
	output logic                         done
);
	import lsu_pkg::*;

	typedef enum logic [1:0] {
		W_IDLE,
		W_ADDR_WAIT,
		W_DATA_WAIT,
		W_RESP_WAIT
	} wr_state_e;

	wr_state_e         state;
	logic              second;
	logic [ID_W-1:0]   id_cnt;
	logic [ID_W-1:0]   issued_id;
	logic              b_match;
	beat_t             cur;
	logic [DATA_W-1:0] beat_data;

	assign awvalid = (state == W_ADDR_WAIT);
	assign wvalid  = (state == W_DATA_WAIT);
	assign bready  = (state == W_RESP_WAIT);
	assign b_match = bvalid && (b.id == issued_id);

	assign cur = second ? plan.second : plan.first;

	// low bytes go up into the first word, the rest down into the next
	assign beat_data = second ? (store_data >> cur.shift) : (store_data << cur.shift);

	always_comb begin
		aw.addr = cur.addr;
		aw.id   = id_cnt;
		aw.size = plan.size;

		w.data = {2{beat_data}};
		w.strb = {2{cur.strb}};
		w.last = 1'b1;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= W_IDLE;
			second    <= 1'b0;
			id_cnt    <= '0;
			issued_id <= '0;
			done      <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				W_IDLE: begin
					if (start) begin
						second <= 1'b0;
						state  <= W_ADDR_WAIT;
					end
				end
				W_ADDR_WAIT: begin
					if (awready) begin
						issued_id <= id_cnt;
						id_cnt    <= id_cnt + 1'b1;
						state     <= W_DATA_WAIT;
					end
				end
				W_DATA_WAIT: begin
					if (wready)
						state <= W_RESP_WAIT;
				end
				W_RESP_WAIT: begin
					if (b_match) begin
						if (plan.need_second && !second) begin
							// rerun the whole sequence for the spill word
							second <= 1'b1;
							state  <= W_ADDR_WAIT;
						end else begin
							done  <= 1'b1;
							state <= W_IDLE;
						end
					end
				end
				default: state <= W_IDLE;
			endcase
		end
	end

endmodule

// ==== logic/load_merge.sv ====
`timescale 1ns/1ps

module load_merge (
	input  lsu_pkg::mem_op_e             op,
	input  lsu_pkg::access_plan_t        plan,
	input  logic [lsu_pkg::DATA_W-1:0]   first_word,
	input  logic [lsu_pkg::DATA_W-1:0]   last_word,
	output logic [lsu_pkg::DATA_W-1:0]   load_data
);
	import lsu_pkg::*;

	logic [DATA_W-1:0]   merged;
	logic [2*DATA_W-1:0] doubled;
	logic [DATA_W-1:0]   rotated;

	// pick each lane from whichever beat carried it
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			if (plan.first.strb[i])
				merged[8*i +: 8] = first_word[8*i +: 8];
			else
				merged[8*i +: 8] = last_word[8*i +: 8];
		end
	end

	// first beat shift is 8*off, so it doubles as the rotate amount
	assign doubled = {merged, merged} >> plan.first.shift;
	assign rotated = doubled[DATA_W-1:0];

	always_comb begin
		case (op)
			LB:      load_data = {{24{rotated[7]}}, rotated[7:0]};
			LBU:     load_data = {24'b0, rotated[7:0]};
			LH:      load_data = {{16{rotated[15]}}, rotated[15:0]};
			LHU:     load_data = {16'b0, rotated[15:0]};
			default: load_data = rotated;
		endcase
	end

endmodule

// ==== logic/lsu_stage.sv ====
`timescale 1ns/1ps

module lsu_stage (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         req_valid,
	input  lsu_pkg::lsu_req_t            req,
	output logic                         allowin,
	output lsu_pkg::axi_ar_t             ar,
	output logic                         arvalid,
	input  logic                         arready,
	input  lsu_pkg::axi_r_t              r,
	input  logic                         rvalid,
	output logic                         rready,
	output lsu_pkg::axi_aw_t             aw,
	output logic                         awvalid,
	input  logic                         awready,
	output lsu_pkg::axi_w_t              w,
	output logic                         wvalid,
	input  logic                         wready,
	input  lsu_pkg::axi_b_t              b,
	input  logic                         bvalid,
	output logic                         bready,
	output logic                         wb_valid,
	output logic [lsu_pkg::REG_W-1:0]    wb_rd,
	output logic [lsu_pkg::DATA_W-1:0]   wb_data
);
	import lsu_pkg::*;

	lsu_req_t          req_q;
	logic              valid_q;
	access_plan_t      plan;
	logic              rd_start;
	logic              wr_start;
	logic              rd_done;
	logic              wr_done;
	logic              done;
	logic [DATA_W-1:0] first_word;
	logic [DATA_W-1:0] last_word;
	logic [DATA_W-1:0] load_data;

	assign done    = rd_done | wr_done;
	assign allowin = !valid_q || done;

	always_ff @(posedge clock) begin
		if (reset)
			valid_q <= 1'b0;
		else if (allowin)
			valid_q <= req_valid;
	end

	always_ff @(posedge clock) begin
		if (allowin && req_valid)
			req_q <= req;
	end

	// hold off in the done cycle, the old request is still in req_q
	assign rd_start = valid_q && !done && is_load(req_q.op);
	assign wr_start = valid_q && !done && is_store(req_q.op);

	lsu_access_planner u_planner (
		.op   (req_q.op),
		.addr (req_q.addr),
		.plan (plan)
	);

	axi_read_ctrl u_read_ctrl (
		.clock      (clock),
		.reset      (reset),
		.start      (rd_start),
		.plan       (plan),
		.ar         (ar),
		.arvalid    (arvalid),
		.arready    (arready),
		.r          (r),
		.rvalid     (rvalid),
		.rready     (rready),
		.first_word (first_word),
		.last_word  (last_word),
		.done       (rd_done)
	);

	axi_write_ctrl u_write_ctrl (
		.clock      (clock),
		.reset      (reset),
		.start      (wr_start),
		.plan       (plan),
		.store_data (req_q.data),
		.aw         (aw),
		.awvalid    (awvalid),
		.awready    (awready),
		.w          (w),
		.wvalid     (wvalid),
		.wready     (wready),
		.b          (b),
		.bvalid     (bvalid),
		.bready     (bready),
		.done       (wr_done)
	);

	load_merge u_load_merge (
		.op         (req_q.op),
		.plan       (plan),
		.first_word (first_word),
		.last_word  (last_word),
		.load_data  (load_data)
	);

	// stores retire without a register write
	assign wb_valid = rd_done;
	assign wb_rd    = req_q.rd;
	assign wb_data  = load_data;

endmodule

// ==== tests/axi_mem_slave.sv ====
`timescale 1ns/1ps

module axi_mem_slave (
	input  logic              clock,
	input  logic              reset,
	input  lsu_pkg::axi_ar_t  ar,
	input  logic              arvalid,
	output logic              arready,
	output lsu_pkg::axi_r_t   r,
	output logic              rvalid,
	input  logic              rready,
	input  lsu_pkg::axi_aw_t  aw,
	input  logic              awvalid,
	output logic              awready,
	input  lsu_pkg::axi_w_t   w,
	input  logic              wvalid,
	output logic              wready,
	output lsu_pkg::axi_b_t   b,
	output logic              bvalid,
	input  logic              bready
);
	import lsu_pkg::*;

	logic [7:0]      mem [logic [31:0]];
	logic [31:0]     lfsr = 32'ha769;
	logic [1:0]      ar_wait = '0;
	logic [1:0]      aw_wait = '0;
	logic [1:0]      w_wait = '0;
	logic [1:0]      r_wait;
	logic [1:0]      b_wait;
	logic            r_pending;
	logic            b_pending;
	logic            r_foreign;
	logic            b_foreign;
	logic [31:0]     rd_addr;
	logic [31:0]     wr_addr;
	logic [ID_W-1:0] rd_id;
	logic [ID_W-1:0] wr_id;

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// unwritten bytes come from a pattern over the full address
	function automatic logic [31:0] read_word(input logic [31:0] a);
		logic [31:0] v;
		for (int i = 0; i < 4; i++) begin
			if (mem.exists(a + 32'(i)))
				v[8*i +: 8] = mem[a + 32'(i)];
			else
				v[8*i +: 8] = (a[7:0] + 8'(i)) ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h3c;
		end
		return v;
	endfunction

	assign arready = arvalid && (ar_wait == 2'd0);
	assign awready = awvalid && (aw_wait == 2'd0);
	assign wready  = wvalid && (w_wait == 2'd0);

	always @(posedge clock) begin
		if (reset) begin
			r_pending <= 1'b0;
			b_pending <= 1'b0;
			rvalid    <= 1'b0;
			bvalid    <= 1'b0;
			r         <= '0;
			b         <= '0;
		end else begin
			if (arvalid && !arready)
				ar_wait <= ar_wait - 2'd1;
			if (arvalid && arready) begin
				ar_wait   <= 2'(random_bits(2));
				r_wait    <= 2'(random_bits(2));
				r_foreign <= (random_bits(2) == 32'd0);
				rd_addr   <= ar.addr;
				rd_id     <= ar.id;
				r_pending <= 1'b1;
			end
			if (r_pending && !rvalid) begin
				if (r_wait != 2'd0) begin
					r_wait <= r_wait - 2'd1;
				end else begin
					// a foreign id goes out first, with corrupted data
					rvalid <= 1'b1;
					r.id   <= r_foreign ? rd_id + 4'd8 : rd_id;
					r.data <= {2{r_foreign ? ~read_word(rd_addr) : read_word(rd_addr)}};
					r.resp <= RESP_OKAY;
					r.last <= 1'b1;
				end
			end else if (rvalid && r.id != rd_id) begin
				r.id   <= rd_id;
				r.data <= {2{read_word(rd_addr)}};
			end else if (rvalid && rready) begin
				rvalid    <= 1'b0;
				r_pending <= 1'b0;
			end

			if (awvalid && !awready)
				aw_wait <= aw_wait - 2'd1;
			if (awvalid && awready) begin
				aw_wait <= 2'(random_bits(2));
				wr_addr <= aw.addr;
				wr_id   <= aw.id;
			end
			if (wvalid && !wready)
				w_wait <= w_wait - 2'd1;
			if (wvalid && wready) begin
				for (int i = 0; i < 4; i++) begin
					if (w.strb[i])
						mem[wr_addr + 32'(i)] = w.data[8*i +: 8];
				end
				w_wait    <= 2'(random_bits(2));
				b_wait    <= 2'(random_bits(2));
				b_foreign <= (random_bits(2) == 32'd0);
				b_pending <= 1'b1;
			end
			if (b_pending && !bvalid) begin
				if (b_wait != 2'd0) begin
					b_wait <= b_wait - 2'd1;
				end else begin
					bvalid <= 1'b1;
					b.id   <= b_foreign ? wr_id + 4'd8 : wr_id;
					b.resp <= RESP_OKAY;
				end
			end else if (bvalid && b.id != wr_id) begin
				b.id <= wr_id;
			end else if (bvalid && bready) begin
				bvalid    <= 1'b0;
				b_pending <= 1'b0;
			end
		end
	end

endmodule

// ==== tests/lsu_tb.sv ====
`timescale 1ns/1ps

module lsu_tb;
	import lsu_pkg::*;

	localparam int N_OPS = 400;
	localparam int RESET_CYCLES = 16;
	localparam logic [31:0] WINDOW_BASE = 32'h0000_8000;

	logic              clock;
	logic              reset;
	logic              req_valid;
	lsu_req_t          req;
	logic              allowin;
	axi_ar_t           ar;
	logic              arvalid;
	logic              arready;
	axi_r_t            r;
	logic              rvalid;
	logic              rready;
	axi_aw_t           aw;
	logic              awvalid;
	logic              awready;
	axi_w_t            w;
	logic              wvalid;
	logic              wready;
	axi_b_t            b;
	logic              bvalid;
	logic              bready;
	logic              wb_valid;
	logic [REG_W-1:0]  wb_rd;
	logic [DATA_W-1:0] wb_data;

	// reference memory with the slave's fill pattern for unstored bytes
	logic [7:0]        model [logic [31:0]];
	logic [31:0]       lfsr;
	int                errors = 0;
	int                loads = 0;

	// access in flight as seen by the bus monitor
	lsu_req_t          cur = '0;
	logic [2:0]        cur_size = SIZE_WORD;
	int                ar_count = 0;
	int                aw_count = 0;
	int                w_count = 0;
	// last issued ids start at all ones so the first expected id is 0
	logic [ID_W-1:0]   rd_id = '1;
	logic [ID_W-1:0]   wr_id = '1;
	logic              ar_stall = 1'b0;
	logic              aw_stall = 1'b0;
	logic              w_stall = 1'b0;
	logic              r_foreign = 1'b0;
	logic              b_foreign = 1'b0;
	axi_ar_t           ar_held;
	axi_aw_t           aw_held;
	axi_w_t            w_held;

	lsu_stage u_lsu_stage (.*);
	axi_mem_slave u_axi_mem_slave (.*);

	always #10 clock = ~clock;

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic [7:0] model_byte(input logic [31:0] a);
		logic [31:0] base;
		base = {a[31:2], 2'b00};
		if (model.exists(a))
			return model[a];
		return (base[7:0] + 8'(a[1:0])) ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h3c;
	endfunction

	function automatic int access_bytes(input mem_op_e op);
		case (op)
			LB, LBU, SB: return 1;
			LH, LHU, SH: return 2;
			default:     return 4;
		endcase
	endfunction

	function automatic int beat_count(input lsu_req_t q);
		return (int'(q.addr[1:0]) + access_bytes(q.op) > 4) ? 2 : 1;
	endfunction

	function automatic logic [31:0] beat_addr(input lsu_req_t q, input int beat);
		return {q.addr[31:2], 2'b00} + 32'(4 * beat);
	endfunction

	function automatic logic [3:0] beat_strb(input lsu_req_t q, input int beat);
		logic [7:0] wide;
		wide = ((8'd1 << access_bytes(q.op)) - 8'd1) << q.addr[1:0];
		return (beat == 0) ? wide[3:0] : wide[7:4];
	endfunction

	function automatic logic [31:0] beat_data(input lsu_req_t q, input int beat);
		int lsb;
		lsb = 8 * q.addr[1:0];
		return (beat == 0) ? (q.data << lsb) : (q.data >> (32 - lsb));
	endfunction

	// little endian bytes from the model and their extension
	function automatic logic [31:0] expected_load(input lsu_req_t q);
		logic [31:0] raw;
		for (int i = 0; i < 4; i++)
			raw[8*i +: 8] = model_byte(q.addr + 32'(i));
		case (q.op)
			LB:      return {{24{raw[7]}}, raw[7:0]};
			LBU:     return {24'b0, raw[7:0]};
			LH:      return {{16{raw[15]}}, raw[15:0]};
			LHU:     return {16'b0, raw[15:0]};
			default: return raw;
		endcase
	endfunction

	task automatic report_mismatch(input string what);
		errors++;
		$display("** Error at %0d ns: %s", $time, what);
	endtask

	task automatic run_access();
		lsu_req_t    q;
		logic        uart;
		logic [31:0] want;
		q.op   = mem_op_e'(3'(random_bits(3)));
		uart   = (random_bits(3) == 32'd7);
		q.addr = (uart ? UART_BASE : WINDOW_BASE) + random_bits(6);
		q.data = random_bits(32);
		q.rd   = REG_W'(random_bits(REG_W));
		want   = expected_load(q);
		@(posedge clock);
		cur      = q;
		cur_size = uart ? SIZE_BYTE : SIZE_WORD;
		ar_count = 0;
		aw_count = 0;
		w_count  = 0;
		req_valid <= 1'b1;
		req       <= q;
		do @(negedge clock); while (!allowin);
		@(posedge clock);
		req_valid <= 1'b0;
		// allowin comes back in the cycle the access completes
		do @(negedge clock); while (!allowin);
		if (q.op inside {SB, SH, SW}) begin
			assert (!wb_valid && ar_count == 0 && aw_count == beat_count(q) && w_count == aw_count)
				else report_mismatch($sformatf("%s at %h: %0d AW, %0d W, expected %0d",
					q.op.name(), q.addr, aw_count, w_count, beat_count(q)));
			for (int i = 0; i < access_bytes(q.op); i++)
				model[q.addr + 32'(i)] = q.data[8*i +: 8];
		end else begin
			loads++;
			assert (wb_valid && wb_rd == q.rd && wb_data == want)
				else report_mismatch($sformatf("%s at %h gave rd %0d data %h, expected rd %0d data %h",
					q.op.name(), q.addr, wb_rd, wb_data, q.rd, want));
			assert (aw_count == 0 && ar_count == beat_count(q))
				else report_mismatch($sformatf("%s at %h: %0d AR, expected %0d",
					q.op.name(), q.addr, ar_count, beat_count(q)));
		end
	endtask

	// everything settles half a cycle after the edge
	always @(negedge clock) begin
		if (!reset) begin
			assert (!allowin || !(arvalid || rready || awvalid || wvalid || bready))
				else report_mismatch("allowin high while an access is on the bus");
			if (ar_stall)
				assert (arvalid && ar == ar_held)
					else report_mismatch("AR valid or payload changed before its handshake");
			if (aw_stall)
				assert (awvalid && aw == aw_held)
					else report_mismatch("AW valid or payload changed before its handshake");
			if (w_stall)
				assert (wvalid && w == w_held)
					else report_mismatch("W valid or payload changed before its handshake");
			if (r_foreign)
				assert (rready && !wb_valid)
					else report_mismatch("R with a foreign id was accepted");
			if (b_foreign)
				assert (bready)
					else report_mismatch("B with a foreign id was accepted");
			if (arvalid && arready) begin
				assert (ar.addr == beat_addr(cur, ar_count) && ar.size == cur_size
						&& ar.id == ID_W'(rd_id + 1'b1))
					else report_mismatch($sformatf("AR beat %0d addr %h size %0d id %0d",
						ar_count, ar.addr, ar.size, ar.id));
				rd_id = ar.id;
				ar_count++;
			end
			if (awvalid && awready) begin
				assert (aw.addr == beat_addr(cur, aw_count) && aw.size == cur_size
						&& aw.id == ID_W'(wr_id + 1'b1))
					else report_mismatch($sformatf("AW beat %0d addr %h size %0d id %0d",
						aw_count, aw.addr, aw.size, aw.id));
				wr_id = aw.id;
				aw_count++;
			end
			if (wvalid)
				assert (w_count < aw_count)
					else report_mismatch("W raised before its AW handshake");
			if (wvalid && wready) begin
				assert (w.strb == {2{beat_strb(cur, w_count)}} && w.last
						&& w.data == {2{beat_data(cur, w_count)}})
					else report_mismatch($sformatf("W beat %0d strb %h data %h last %b",
						w_count, w.strb, w.data, w.last));
				w_count++;
			end
			ar_stall  = arvalid && !arready;
			aw_stall  = awvalid && !awready;
			w_stall   = wvalid && !wready;
			ar_held   = ar;
			aw_held   = aw;
			w_held    = w;
			r_foreign = rvalid && rready && (r.id != rd_id);
			b_foreign = bvalid && bready && (b.id != wr_id);
		end
	end

	initial begin
		clock     = 1'b0;
		reset     = 1'b1;
		req_valid = 1'b0;
		req       = '0;
		lfsr      = 32'ha769;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		assert (!arvalid && !awvalid && !wvalid && !rready && !bready && !wb_valid && allowin)
			else report_mismatch("bus or writeback active right after reset");
		for (int n = 0; n < N_OPS; n++)
			run_access();
		$display("accesses %0d, loads %0d, errors %0d", N_OPS, loads, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// worst case access stays well under 40 cycles
	initial begin
		#((RESET_CYCLES + N_OPS * 40) * 20);
		$display("Timeout: accesses stopped completing, %0d errors so far", errors);
		$display("Regression failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
logic/lsu_pkg.sv
logic/lsu_access_planner.sv
logic/axi_read_ctrl.sv
logic/axi_write_ctrl.sv
logic/load_merge.sv
logic/lsu_stage.sv
tests/axi_mem_slave.sv
tests/lsu_tb.sv
